// File: Makefile
# Verilator build and run of the APB arithmetic coprocessor testbench

VERILATOR ?= verilator
TOP       ?= alu_apb_tb
FILELIST  ?= alu_apb_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: alu_apb_top.f
hw/apb_pkg.sv
hw/alu_pkg.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/alu_apb_top.sv
tb/alu_apb_asserts.sv
tb/alu_apb_tb.sv

// File: hw/alu_apb_top.sv
/* Top level of the APB arithmetic coprocessor. Packs the bus and wires
   decode, execute and result in sequence */
`timescale 1ns/10ps

module alu_apb_top #(
    parameter int ADDR_W  = 8,
    parameter int COUNT_W = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);

    apb_pkg::apb_req_t   apb_req;
    alu_pkg::alu_req_t   req;        // decode -> execute
    alu_pkg::alu_out_t   out;        // execute -> result
    alu_pkg::alu_flags_t flag_wdata;
    alu_pkg::alu_flags_t flags;      // visible copy
    logic                flag_wr;
    logic [31:0]         result;
    logic [COUNT_W-1:0]  count;

    assign apb_req.psel    = psel;
    assign apb_req.penable = penable;
    assign apb_req.pwrite  = pwrite;
    assign apb_req.paddr   = paddr;
    assign apb_req.pwdata  = pwdata;

    alu_decode #(
        .ADDR_W  (ADDR_W),
        .COUNT_W (COUNT_W)
    ) alu_decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb        (apb_req),
        .result     (result),
        .flags      (flags),
        .count      (count),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .req        (req),
        .flag_wr    (flag_wr),
        .flag_wdata (flag_wdata)
    );

    alu_execute alu_execute_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .flag_wr    (flag_wr),
        .flag_wdata (flag_wdata),
        .out        (out)
    );

    alu_result #(
        .COUNT_W (COUNT_W)
    ) alu_result_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .out    (out),
        .result (result),
        .flags  (flags),
        .count  (count)
    );

endmodule

// File: hw/alu_decode.sv
/* APB slave of the coprocessor: operand registers, control word check,
   request issue and the read multiplexer. Zero wait states */
`timescale 1ns/10ps

module alu_decode #(
    parameter int ADDR_W  = 8,
    parameter int COUNT_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   apb,
    input  logic [31:0]         result,
    input  alu_pkg::alu_flags_t flags,
    input  logic [COUNT_W-1:0]  count,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output alu_pkg::alu_req_t   req,
    output logic                flag_wr,
    output alu_pkg::alu_flags_t flag_wdata
);

    localparam logic [31:0] CTRL_MASK = 32'h0000_0137; // op, width, sel_imm

    logic [31:0]       op0_q, op1_q, imm_q;  // operand payload
    logic [31:0]       ctrl_q;               // last accepted control word
    logic [ADDR_W-1:0] addr;
    logic              access, wr_acc;
    logic [2:0]        ctrl_op;
    logic [1:0]        ctrl_w;
    logic              op_ok, w_ok, ctrl_legal, ctrl_fire;
    logic              addr_err;
    logic [31:0]       rdata;

    assign addr    = apb.paddr;
    assign access  = apb.psel & apb.penable;  // access phase, always completes
    assign wr_acc  = access & apb.pwrite;
    assign ctrl_op = apb.pwdata[alu_pkg::CTRL_OP_MSB:alu_pkg::CTRL_OP_LSB];
    assign ctrl_w  = apb.pwdata[alu_pkg::CTRL_W_MSB:alu_pkg::CTRL_W_LSB];

    // legality of the control word
    always_comb begin
        case (alu_pkg::alu_op_e'(ctrl_op))
            alu_pkg::OP_MOVE, alu_pkg::OP_ADD, alu_pkg::OP_ADC,
            alu_pkg::OP_AND, alu_pkg::OP_MDEC1: op_ok = 1'b1;
            default:                            op_ok = 1'b0;
        endcase
        case (alu_pkg::alu_width_e'(ctrl_w))
            alu_pkg::W_BYTE, alu_pkg::W_WORD, alu_pkg::W_LONG: w_ok = 1'b1;
            default:                                           w_ok = 1'b0;
        endcase
    end
    assign ctrl_legal = op_ok & w_ok;
    assign ctrl_fire  = wr_acc & (addr == ADDR_W'(apb_pkg::REG_CTRL)) & ctrl_legal;

    // address decode, read data and error response
    always_comb begin
        rdata    = 32'd0;
        addr_err = 1'b0;
        case (addr)
            ADDR_W'(apb_pkg::REG_OP0):   rdata = op0_q;
            ADDR_W'(apb_pkg::REG_OP1):   rdata = op1_q;
            ADDR_W'(apb_pkg::REG_IMM):   rdata = imm_q;
            ADDR_W'(apb_pkg::REG_CTRL): begin
                rdata    = ctrl_q;
                addr_err = apb.pwrite & ~ctrl_legal; // bad op or width
            end
            ADDR_W'(apb_pkg::REG_RESULT): begin
                rdata    = result;
                addr_err = apb.pwrite;               // read only
            end
            ADDR_W'(apb_pkg::REG_FLAGS): rdata = {24'd0, flags};
            ADDR_W'(apb_pkg::REG_COUNT): begin
                rdata    = 32'(count);               // zero extended
                addr_err = apb.pwrite;
            end
            default: addr_err = 1'b1;                // unmapped
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & addr_err;
    assign prdata  = (access & ~apb.pwrite) ? rdata : 32'd0;

    // operand registers, no reset
    always_ff @(posedge clk) begin
        if (wr_acc && addr == ADDR_W'(apb_pkg::REG_OP0)) op0_q <= apb.pwdata;
        if (wr_acc && addr == ADDR_W'(apb_pkg::REG_OP1)) op1_q <= apb.pwdata;
        if (wr_acc && addr == ADDR_W'(apb_pkg::REG_IMM)) imm_q <= apb.pwdata;
    end

    // request and flag write, one cycle pulses after the access edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
            flag_wr   <= 1'b0;
            ctrl_q    <= 32'd0;
        end else begin
            req.valid <= ctrl_fire;
            flag_wr   <= wr_acc & (addr == ADDR_W'(apb_pkg::REG_FLAGS));
            if (ctrl_fire) ctrl_q <= apb.pwdata & CTRL_MASK;
        end
        if (ctrl_fire) begin
            req.op      <= alu_pkg::alu_op_e'(ctrl_op);
            req.width   <= alu_pkg::alu_width_e'(ctrl_w);
            req.sel_imm <= apb.pwdata[alu_pkg::CTRL_SEL_IMM];
            req.op0     <= op0_q;  // operands as of the launch
            req.op1     <= op1_q;
            req.imm     <= imm_q;
        end
        flag_wdata <= alu_pkg::alu_flags_t'(apb.pwdata[7:0]);
    end

endmodule

// File: hw/alu_execute.sv
/* ALU datapath with the architectural flag register. One request per
   cycle, outcome registered one cycle after the request */
`timescale 1ns/10ps

module alu_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  alu_pkg::alu_req_t   req,
    input  logic                flag_wr,
    input  alu_pkg::alu_flags_t flag_wdata,
    output alu_pkg::alu_out_t   out
);

    alu_pkg::alu_flags_t flags_q, nx_flags, wr_flags;
    logic [31:0] op2, sum, rslt;
    logic [15:0] mdec;
    logic        cin;
    logic        c_nib, c_byte, c_word, c_long; // carries out of bits 3, 7, 15, 31
    logic        rs, rz, par, carry_w;          // result traits at the width
    logic        op0_s, op2_s;

    assign op2 = req.sel_imm ? req.imm : req.op1;
    assign cin = (req.op == alu_pkg::OP_ADC) & flags_q.c; // adc chains carry

    // adder split where the flags tap the carries
    assign {c_nib, sum[3:0]}    = {1'b0, req.op0[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
    assign {c_byte, sum[7:4]}   = {1'b0, req.op0[7:4]} + {1'b0, op2[7:4]} + {4'd0, c_nib};
    assign {c_word, sum[15:8]}  = {1'b0, req.op0[15:8]} + {1'b0, op2[15:8]} + {8'd0, c_byte};
    assign {c_long, sum[31:16]} = {1'b0, req.op0[31:16]} + {1'b0, op2[31:16]}
                                + {16'd0, c_word};

    // set bits of op0 if none overlap op2, else step down
    assign mdec = ((req.op0[15:0] & op2[15:0]) == 16'd0) ? (req.op0[15:0] | op2[15:0])
                                                         : req.op0[15:0] - 16'd1;

    always_comb begin
        case (req.op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADC: rslt = sum;
            alu_pkg::OP_AND:   rslt = req.op0 & op2;
            alu_pkg::OP_MDEC1: rslt = {req.op0[31:16], mdec}; // upper half kept
            default:           rslt = req.sel_imm ? req.imm : req.op0; // move
        endcase
    end

    // sign, zero, parity and carry at the requested width
    always_comb begin
        case (req.width)
            alu_pkg::W_BYTE: begin
                rs      = rslt[7];
                rz      = rslt[7:0] == 8'd0;
                par     = ~^rslt[7:0];
                carry_w = c_byte;
                op0_s   = req.op0[7];
                op2_s   = op2[7];
            end
            alu_pkg::W_WORD: begin
                rs      = rslt[15];
                rz      = rslt[15:0] == 16'd0;
                par     = ~^rslt[15:0];
                carry_w = c_word;
                op0_s   = req.op0[15];
                op2_s   = op2[15];
            end
            default: begin         // long
                rs      = rslt[31];
                rz      = rslt == 32'd0;
                par     = ~^rslt;
                carry_w = c_long;
                op0_s   = req.op0[31];
                op2_s   = op2[31];
            end
        endcase
    end

    always_comb begin
        nx_flags = flags_q;        // move and mdec1 leave flags alone
        case (req.op)
            alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
                nx_flags.s = rs;
                nx_flags.z = rz;
                nx_flags.h = c_nib;
                nx_flags.v = (op0_s == op2_s) & (rs != op0_s); // signed overflow
                nx_flags.n = 1'b0;
                nx_flags.c = carry_w;
            end
            alu_pkg::OP_AND: begin
                nx_flags.s = rs;
                nx_flags.z = rz;
                nx_flags.h = 1'b1;
                nx_flags.v = par;  // even parity
                nx_flags.n = 1'b0;
                nx_flags.c = 1'b0;
            end
            default: ;
        endcase
    end

    // software flag write, reserved bits stay 0
    always_comb begin
        wr_flags      = flag_wdata;
        wr_flags.rsv5 = 1'b0;
        wr_flags.rsv3 = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            flags_q   <= '0;
        end else begin
            out.valid <= req.valid;
            if (req.valid) flags_q <= nx_flags;     // request wins over flag write
            else if (flag_wr) flags_q <= wr_flags;
        end
        out.result <= rslt;
        out.flags  <= nx_flags;
    end

endmodule

// File: hw/alu_pkg.sv
/* Opcodes, widths, flag layout and the structs that carry an operation
   through decode, execute and result */
package alu_pkg;

    // codes 5..7 rejected by decode
    typedef enum logic [2:0] {
        OP_MOVE  = 3'd0,
        OP_ADD   = 3'd1,
        OP_ADC   = 3'd2,
        OP_AND   = 3'd3,
        OP_MDEC1 = 3'd4  // modulo decrement
    } alu_op_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2    // code 3 illegal
    } alu_width_e;

    // cpu style flag byte, msb first
    typedef struct packed {
        logic s;     // sign
        logic z;     // zero
        logic rsv5;  // reads 0
        logic h;     // half carry
        logic rsv3;  // reads 0
        logic v;     // overflow / parity
        logic n;     // negative (subtract)
        logic c;     // carry
    } alu_flags_t;

    // one issued operation
    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        alu_width_e  width;
        logic        sel_imm; // imm replaces op1
        logic [31:0] op0;
        logic [31:0] op1;
        logic [31:0] imm;
    } alu_req_t;

    // one completed operation
    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        alu_flags_t  flags;
    } alu_out_t;

    // control word fields
    localparam int CTRL_OP_LSB  = 0;
    localparam int CTRL_OP_MSB  = 2;
    localparam int CTRL_W_LSB   = 4;
    localparam int CTRL_W_MSB   = 5;
    localparam int CTRL_SEL_IMM = 8;

endpackage

// File: hw/alu_result.sv
/* Software visible copy of the last completed operation and a wrapping
   count of completed operations, polled by software */
`timescale 1ns/10ps

module alu_result #(
    parameter int COUNT_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  alu_pkg::alu_out_t   out,
    output logic [31:0]         result,
    output alu_pkg::alu_flags_t flags,
    output logic [COUNT_W-1:0]  count
);

    // flag copy only moves on a completed op, so a direct flag write
    // shows up here after the next operation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= 32'd0;
            flags  <= '0;
            count  <= '0;
        end else if (out.valid) begin
            result <= out.result;
            flags  <= out.flags;
            count  <= count + COUNT_W'(1); // wraps
        end
    end

endmodule

// File: hw/apb_pkg.sv
/* APB slave view and register map of the arithmetic coprocessor,
   used by the top level to pack the bus and by the decode stage */
package apb_pkg;

    localparam int ADDR_BITS = 8; // paddr field width

    // slave side of one APB transfer
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [ADDR_BITS-1:0] paddr;
        logic [31:0]          pwdata;
    } apb_req_t;

    // byte offsets
    localparam logic [ADDR_BITS-1:0] REG_OP0    = 8'h00; // first operand
    localparam logic [ADDR_BITS-1:0] REG_OP1    = 8'h04; // second operand
    localparam logic [ADDR_BITS-1:0] REG_IMM    = 8'h08; // immediate
    localparam logic [ADDR_BITS-1:0] REG_CTRL   = 8'h0C; // write launches op
    localparam logic [ADDR_BITS-1:0] REG_RESULT = 8'h10; // read only
    localparam logic [ADDR_BITS-1:0] REG_FLAGS  = 8'h14; // r/w
    localparam logic [ADDR_BITS-1:0] REG_COUNT  = 8'h18; // read only

endpackage

// File: tb/alu_apb_asserts.sv
/* Protocol and pipeline assertions, bound into the coprocessor top level */
`timescale 1ns/10ps

module alu_apb_asserts (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic req_valid,
    input logic out_valid
);

    // zero wait states
    a_pready_high: assert property (@(posedge clk) pready)
        else $error("pready dropped low");

    // error only in an access phase
    a_pslverr_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an access phase");

    // execute is one stage deep
    a_out_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |=> out_valid)
        else $error("out.valid missing one cycle after req.valid");

    a_no_spurious_out: assert property (@(posedge clk) disable iff (!rst_n)
        !req_valid |=> !out_valid)
        else $error("out.valid without a request the cycle before");

endmodule

bind alu_apb_top alu_apb_asserts alu_apb_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .req_valid (req.valid),
    .out_valid (out.valid)
);

// File: tb/alu_apb_tb.sv
/* Testbench of the APB arithmetic coprocessor. Drives operations over APB,
   predicts RESULT and FLAGS with a reference model and compares them */
`timescale 1ns/10ps

module alu_apb_tb;

    localparam int TIMEOUT = 200;              // limit of every wait loop
    localparam logic [2:0] OP_MOVE  = 3'd0;
    localparam logic [2:0] OP_ADD   = 3'd1;
    localparam logic [2:0] OP_ADC   = 3'd2;
    localparam logic [2:0] OP_AND   = 3'd3;
    localparam logic [2:0] OP_MDEC1 = 3'd4;
    localparam logic [1:0] W_BYTE = 2'd0;
    localparam logic [1:0] W_WORD = 2'd1;
    localparam logic [1:0] W_LONG = 2'd2;

    logic        clk, rst_n, psel, penable, pwrite, pready, pslverr;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    integer      seed = 72;
    logic [7:0]  m_flags;                      // model flag state
    logic [31:0] m_result, exp_count;
    logic        cmp_ack;
    event        cmp_req;

    alu_apb_top #(.ADDR_W(8), .COUNT_W(16)) alu_apb_top_inst (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #50 clk = ~clk;                     // 100 ns period

    // expected {flags, result} from the ALU rules
    function automatic logic [39:0] ref_alu(input logic [2:0] op, input logic [1:0] wd,
                                            input logic sel, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] imm,
                                            input logic [7:0] fl);
        logic [31:0] op2, res, mask;
        logic [32:0] wide;
        logic [4:0]  nib;
        logic [7:0]  nf;
        logic        cin;
        int          top;
        op2  = sel ? imm : b;
        top  = (wd == W_BYTE) ? 7 : (wd == W_WORD) ? 15 : 31;
        mask = (wd == W_BYTE) ? 32'hFF : (wd == W_WORD) ? 32'hFFFF : 32'hFFFF_FFFF;
        cin  = (op == OP_ADC) & fl[0];         // carry chains only into adc
        nf   = fl;                             // move and mdec1 keep flags
        case (op)
            OP_ADD, OP_ADC: begin
                res   = a + op2 + {31'd0, cin};
                wide  = {1'b0, a & mask} + {1'b0, op2 & mask} + {32'd0, cin};
                nib   = {1'b0, a[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
                nf[7] = res[top];
                nf[6] = (res & mask) == 32'd0;
                nf[4] = nib[4];                // half carry
                nf[2] = (a[top] == op2[top]) && (res[top] != a[top]);
                nf[1] = 1'b0;
                nf[0] = wide[top+1];           // carry out of the width
            end
            OP_AND: begin
                res   = a & op2;
                nf[7] = res[top];
                nf[6] = (res & mask) == 32'd0;
                nf[4] = 1'b1;
                nf[2] = ~^(res & mask);        // even parity
                nf[1] = 1'b0;
                nf[0] = 1'b0;
            end
            OP_MDEC1: res = {a[31:16], ((a[15:0] & op2[15:0]) == 16'd0) ?
                                       (a[15:0] | op2[15:0]) : (a[15:0] - 16'd1)};
            default: res = sel ? imm : a;      // move
        endcase
        return {nf, res};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one APB transfer entered and left at a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        psel    <= 1'b1;                       // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;                       // access phase
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > TIMEOUT) begin
                $display("Simulation failed");
                $fatal(1, "APB transfer never saw pready");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;                       // overridden by a following setup
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("PSLVERR", 32'(err), 32'(exp_err));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_value("PSLVERR", 32'(err), 32'd0);
    endtask

    // launch via CTRL and step the model
    task automatic issue(input logic [2:0] op, input logic [1:0] wd, input logic sel,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
        apb_write(apb_pkg::REG_CTRL, {23'd0, sel, 2'd0, wd, 1'b0, op}, 1'b0);
        {m_flags, m_result} = ref_alu(op, wd, sel, a, b, imm, m_flags);
        exp_count = exp_count + 32'd1;
    endtask

    // hand over to the compare process and wait for it
    task automatic sync_compare;
        int n;
        cmp_ack = 1'b0;
        -> cmp_req;
        n = 0;
        @(negedge clk);
        while (!cmp_ack) begin
            n++;
            if (n > 4 * TIMEOUT) begin
                $display("Simulation failed");
                $fatal(1, "compare process did not finish in time");
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic run_op(input logic [2:0] op, input logic [1:0] wd, input logic sel,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
        apb_write(apb_pkg::REG_OP0, a, 1'b0);
        apb_write(apb_pkg::REG_OP1, b, 1'b0);
        apb_write(apb_pkg::REG_IMM, imm, 1'b0);
        issue(op, wd, sel, a, b, imm);
        sync_compare();
    endtask

    task automatic write_flags(input logic [7:0] v);
        apb_write(apb_pkg::REG_FLAGS, {24'd0, v}, 1'b0);
        m_flags = v & 8'hD7;                   // bits 5 and 3 read 0
    endtask

    // polls COUNT then checks RESULT and FLAGS
    always begin : compare_proc
        logic [31:0] rd;
        int          polls;
        @(cmp_req);
        @(posedge clk);
        polls = 0;
        apb_read(apb_pkg::REG_COUNT, rd);
        while (rd != exp_count) begin
            polls++;
            if (polls > TIMEOUT) begin
                $display("Simulation failed");
                $fatal(1, "COUNT never reached the expected number of operations");
            end
            apb_read(apb_pkg::REG_COUNT, rd);
        end
        apb_read(apb_pkg::REG_RESULT, rd);
        check_value("RESULT", rd, m_result);
        apb_read(apb_pkg::REG_FLAGS, rd);
        check_value("FLAGS", rd, {24'd0, m_flags});
        cmp_ack = 1'b1;
    end

    initial begin : stimulus
        logic [31:0] a, b, imm, rd, mask, pos;
        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'd0;
        pwdata = 32'd0;
        m_flags = 8'd0;
        m_result = 32'd0;
        exp_count = 32'd0;
        cmp_ack = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // move and and over every width with and without imm
        for (int w = 0; w < 3; w++) begin
            for (int s = 0; s < 2; s++) begin
                run_op(OP_MOVE, 2'(w), 1'(s), $random(seed), $random(seed), $random(seed));
                run_op(OP_AND, 2'(w), 1'(s), $random(seed), $random(seed), $random(seed));
            end
        end

        // add then adc forcing V, H, C, Z and the carry chain
        for (int w = 0; w < 3; w++) begin
            mask = (w == 0) ? 32'hFF : (w == 1) ? 32'hFFFF : 32'hFFFF_FFFF;
            pos  = mask >> 1;                  // largest positive at the width
            a    = $random(seed);
            run_op(OP_ADD, 2'(w), 1'b0, (a & ~mask) | pos, 32'd1, 32'd0);
            run_op(OP_ADD, 2'(w), 1'b1, (a & ~mask) | mask, 32'd0, 32'd1);
            run_op(OP_ADC, 2'(w), 1'b0, 32'd0, 32'd0, 32'd0);   // takes carry in
            run_op(OP_ADC, 2'(w), 1'b0, pos, pos, 32'd0);
        end

        // mdec1 both branches
        run_op(OP_MDEC1, W_LONG, 1'b0, 32'h1234_00F0, 32'h0000_0F00, 32'd0); // disjoint
        run_op(OP_MDEC1, W_WORD, 1'b1, 32'hABCD_0010, 32'd0, 32'h0000_0011); // overlap
        run_op(OP_MDEC1, W_BYTE, 1'b0, 32'h8000_0000, 32'hFFFF_0000, 32'd0);

        // direct flag writes feed adc
        write_flags(8'h01);
        run_op(OP_ADC, W_LONG, 1'b0, 32'd5, 32'd7, 32'd0);
        write_flags(8'h00);
        run_op(OP_ADC, W_LONG, 1'b0, 32'd5, 32'd7, 32'd0);
        write_flags(8'hFF);
        run_op(OP_MOVE, W_BYTE, 1'b1, 32'd0, 32'd0, 32'h55);
        run_op(OP_ADC, W_BYTE, 1'b0, 32'h0F, 32'h70, 32'd0);

        // error responses issue nothing
        apb_write(apb_pkg::REG_CTRL, 32'h0000_0006, 1'b1);  // opcode 6
        apb_write(apb_pkg::REG_CTRL, 32'h0000_0031, 1'b1);  // width 3
        apb_write(apb_pkg::REG_RESULT, 32'h1, 1'b1);
        apb_write(8'h40, 32'h1, 1'b1);                      // unmapped
        apb_write(apb_pkg::REG_OP0, 32'd0, 1'b0);           // room for a stray issue
        apb_read(apb_pkg::REG_COUNT, rd);
        check_value("COUNT", rd, exp_count);

        // back to back launches without polling in between
        a   = 32'hFFFF_FFF0;
        b   = 32'h0000_0010;
        imm = $random(seed);
        apb_write(apb_pkg::REG_OP0, a, 1'b0);
        apb_write(apb_pkg::REG_OP1, b, 1'b0);
        apb_write(apb_pkg::REG_IMM, imm, 1'b0);
        issue(OP_ADD, W_LONG, 1'b0, a, b, imm);
        issue(OP_ADC, W_BYTE, 1'b0, a, b, imm);
        issue(OP_AND, W_BYTE, 1'b1, a, b, imm);
        issue(OP_ADC, W_WORD, 1'b1, a, b, imm);             // carry feeds the last adc
        issue(OP_ADC, W_LONG, 1'b0, a, b, imm);
        sync_compare();

        $display("Simulation passed");
        $finish;
    end

endmodule
